// File: verilog.f
+incdir+src
src/mips_debug_pkg.sv
src/debug_command_decode.sv
src/instruction_fetch.sv
src/database.sv
src/mips_debug_top.sv
dv/clock_gen.sv
dv/mips_debug_chk.sv
dv/mips_debug_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the debug unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module mips_debug_tb \
    -o mips_debug_sim

./obj_dir/mips_debug_sim

// File: dv/mips_debug_tb.sv
`timescale 1ns/1ps

`include "mips_debug_defines.svh"

module mips_debug_tb;

    import mips_debug_pkg::*;

    localparam int IMEM_AW       = $clog2(`IMEM_WORDS);
    localparam int PAD           = `LONGITUD_INSTRUCCION - `ADDR_LENGTH;
    localparam int RESET_TIMEOUT = 50;
    localparam int HALT_TIMEOUT  = 200;

    logic                             clock;
    logic                             soft_reset;
    logic                             cmd_strobe;
    debug_cmd_e                       cmd;
    logic                             load_en;
    logic [IMEM_AW-1:0]               load_addr;
    logic [`LONGITUD_INSTRUCCION-1:0] load_data;
    logic [`LONGITUD_INSTRUCCION-1:0] dato;
    logic                             halted;
    logic                             running;

    logic [15:0]                      lfsr;
    logic [`LONGITUD_INSTRUCCION-1:0] model_mem [0:`IMEM_WORDS-1];
    logic [`ADDR_LENGTH-1:0]          model_pc;
    logic [`ADDR_LENGTH-1:0]          model_cycles;
    logic [`ADDR_LENGTH-1:0]          snap_pc;
    logic [`ADDR_LENGTH-1:0]          snap_adder;
    logic [`ADDR_LENGTH-1:0]          snap_cycles;
    logic [`LONGITUD_INSTRUCCION-1:0] snap_instr;
    int                               errors;

    clock_gen clock_gen_i (
        .o_clock      (clock),
        .o_soft_reset (soft_reset)
    );

    mips_debug_top dut_i (
        .i_clock      (clock),
        .i_soft_reset (soft_reset),
        .i_cmd_strobe (cmd_strobe),
        .i_cmd        (cmd),
        .i_load_en    (load_en),
        .i_load_addr  (load_addr),
        .i_load_data  (load_data),
        .o_dato       (dato),
        .o_halted     (halted),
        .o_running    (running)
    );

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit and never the halt word.
    function automatic logic [`LONGITUD_INSTRUCCION-1:0] next_program_word();
        logic [`LONGITUD_INSTRUCCION-1:0] w;
        w = '0;
        for (int b = 0; b < `LONGITUD_INSTRUCCION; b++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[`LONGITUD_INSTRUCCION-2:0], lfsr[0]};
        end
        if (w == `HALT_WORD) begin
            w = '0;
        end
        return w;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // all tasks start and end 1 ns after a rising edge.
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    task automatic issue_command(input debug_cmd_e c);
        cmd_strobe = 1'b1;
        cmd        = c;
        @(posedge clock);
        #1;
        cmd_strobe = 1'b0;
        cmd        = CMD_NOP;
    endtask

    task automatic load_word(input logic [IMEM_AW-1:0] addr,
                             input logic [`LONGITUD_INSTRUCCION-1:0] data);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        @(posedge clock);
        #1;
        load_en         = 1'b0;
        model_mem[addr] = data;
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (soft_reset !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (soft_reset !== 1'b1) begin
            $display("reset was never released");
            stop_with_failure();
        end
    endtask

    task automatic wait_for_halt();
        int n;
        n = 0;
        while (halted !== 1'b1 && n < HALT_TIMEOUT) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (halted !== 1'b1) begin
            $display("fetch stage did not halt within %0d cycles", HALT_TIMEOUT);
            stop_with_failure();
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            load_word(i[IMEM_AW-1:0], next_program_word());
        end
    endtask

    task automatic step_once();
        issue_command(CMD_STEP);
        idle_cycles(2);
        model_pc     = model_pc + `ADDR_LENGTH'd4;
        model_cycles = model_cycles + `ADDR_LENGTH'd1;
    endtask

    // capture lands one edge after the strobe is taken.
    task automatic take_snapshot();
        issue_command(CMD_SNAPSHOT);
        idle_cycles(1);
        snap_pc     = model_pc;
        snap_adder  = model_pc + `ADDR_LENGTH'd4;
        snap_cycles = model_cycles;
        snap_instr  = model_mem[model_pc[`ADDR_LENGTH-1:2]];
    endtask

    task automatic read_and_check(input debug_cmd_e c, input logic [31:0] exp,
                                  input string what);
        issue_command(c);
        idle_cycles(2);
        check_equal(dato, exp, what);
    endtask

    task automatic check_snapshot(input string tag);
        read_and_check(CMD_READ_PC, {{PAD{1'b0}}, snap_pc}, {tag, " pc"});
        read_and_check(CMD_READ_ADDER_PC, {{PAD{1'b0}}, snap_adder}, {tag, " next pc"});
        read_and_check(CMD_READ_CYCLES, {{PAD{1'b0}}, snap_cycles}, {tag, " cycles"});
        read_and_check(CMD_READ_INSTR, snap_instr, {tag, " instruction"});
    endtask

    task automatic reset_readout();
        take_snapshot();
        check_snapshot("reset");
    endtask

    task automatic single_step();
        logic [IMEM_AW-1:0] base;
        base = model_pc[`ADDR_LENGTH-1:2];
        for (int i = 0; i <= 5; i++) begin
            load_word(base + i[IMEM_AW-1:0], next_program_word());
        end
        repeat (5) step_once();
        take_snapshot();
        check_snapshot("step");
    endtask

    task automatic run_to_halt();
        logic [IMEM_AW-1:0] start_word;
        logic [IMEM_AW-1:0] halt_index;
        start_word = model_pc[`ADDR_LENGTH-1:2];
        halt_index = start_word + 9'd7;
        load_word(halt_index, `HALT_WORD);
        issue_command(CMD_RUN);
        check_equal({31'd0, running}, 32'd1, "running after run");
        wait_for_halt();
        issue_command(CMD_STOP);
        idle_cycles(2);
        check_equal({31'd0, running}, 32'd0, "running after stop at halt");
        model_cycles = model_cycles + {2'b00, halt_index - start_word};
        model_pc     = {halt_index, 2'b00};
        take_snapshot();
        check_snapshot("halt");
        load_word(halt_index, next_program_word()); // lets the fetch move on.
    endtask

    task automatic held_snapshot();
        take_snapshot();
        repeat (3) step_once();
        check_snapshot("held");
        take_snapshot();
        check_snapshot("refreshed");
    endtask

    task automatic clear_and_stop();
        issue_command(CMD_CLEAR);
        idle_cycles(2);
        snap_pc     = '0;
        snap_adder  = `ADDR_LENGTH'd4;
        snap_cycles = '0;
        snap_instr  = '0;
        check_snapshot("clear");
        // the enable stays high for 7 edges from run to stop.
        issue_command(CMD_RUN);
        check_equal({31'd0, running}, 32'd1, "running after second run");
        idle_cycles(6);
        issue_command(CMD_STOP);
        idle_cycles(2);
        model_pc     = model_pc + `ADDR_LENGTH'd28;
        model_cycles = model_cycles + `ADDR_LENGTH'd7;
        check_equal({31'd0, running}, 32'd0, "running after stop");
        take_snapshot();
        check_snapshot("after run");
        step_once();
        take_snapshot();
        check_snapshot("one step later");
    endtask

    initial begin
        cmd_strobe   = 1'b0;
        cmd          = CMD_NOP;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        lfsr         = 16'd65482;
        errors       = 0;
        model_pc     = '0;
        model_cycles = '0;
        wait_for_reset();
        fill_memory();
        reset_readout();
        single_step();
        run_to_halt();
        held_snapshot();
        clear_and_stop();
        if (errors == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// File: dv/mips_debug_chk.sv
`timescale 1ns/1ps

`include "mips_debug_defines.svh"

module mips_debug_chk (
    input logic                              i_clock,
    input logic                              i_soft_reset,
    input logic [`ADDR_LENGTH-1:0]           i_pc,
    input logic                              i_halted,
    input mips_debug_pkg::db_control_e       i_control,
    input logic [`LONGITUD_INSTRUCCION-1:0]  i_dato
);

    import mips_debug_pkg::*;

    // pc is always a word address.
    pc_aligned_a: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        i_pc[1:0] == 2'b00)
        else $error("program counter is not word aligned");

    // no fetch progress on the halt word.
    pc_stable_halted_a: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        i_halted |=> $stable(i_pc))
        else $error("program counter moved while halted");

    // readout is zeroed by a capture.
    dato_zero_after_capture_a: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        (i_control == DB_CAPTURE) |=> (i_dato == '0))
        else $error("readout not zero after capture");

endmodule

bind instruction_fetch mips_debug_chk fetch_chk_i (
    .i_clock      (i_clock),
    .i_soft_reset (i_soft_reset),
    .i_pc         (o_pc),
    .i_halted     (o_halted),
    .i_control    (mips_debug_pkg::DB_HOLD),
    .i_dato       (`LONGITUD_INSTRUCCION'd0)
);

bind database mips_debug_chk database_chk_i (
    .i_clock      (i_clock),
    .i_soft_reset (i_soft_reset),
    .i_pc         (i_pc),
    .i_halted     (1'b0),
    .i_control    (i_control),
    .i_dato       (o_dato)
);

// File: dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic o_clock,
    output logic o_soft_reset
);

    initial begin
        o_clock = 1'b0;
        forever begin
            #5 o_clock = ~o_clock; // 10 ns period.
        end
    end

    // reset low for the first five rising edges.
    initial begin
        o_soft_reset = 1'b0;
        repeat (5) @(posedge o_clock);
        o_soft_reset <= 1'b1;
    end

endmodule

// File: src/mips_debug_top.sv
`timescale 1ns/1ps

`include "mips_debug_defines.svh"

module mips_debug_top (
    input  logic                             i_clock,
    input  logic                             i_soft_reset,
    input  logic                             i_cmd_strobe,
    input  mips_debug_pkg::debug_cmd_e       i_cmd,
    input  logic                             i_load_en,
    input  logic [$clog2(`IMEM_WORDS)-1:0]   i_load_addr,
    input  logic [`LONGITUD_INSTRUCCION-1:0] i_load_data,
    output logic [`LONGITUD_INSTRUCCION-1:0] o_dato,
    output logic                             o_halted,
    output logic                             o_running
);

    import mips_debug_pkg::*;

    logic                             fetch_enable;
    db_control_e                      control;
    logic [`ADDR_LENGTH-1:0]          pc;
    logic [`ADDR_LENGTH-1:0]          adder_pc;
    logic [`ADDR_LENGTH-1:0]          cycles;
    logic [`LONGITUD_INSTRUCCION-1:0] instruction;

    debug_command_decode decode_i (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_cmd_strobe   (i_cmd_strobe),
        .i_cmd          (i_cmd),
        .o_fetch_enable (fetch_enable),
        .o_control      (control),
        .o_running      (o_running)
    );

    instruction_fetch fetch_i (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_fetch_enable (fetch_enable),
        .i_load_en      (i_load_en),
        .i_load_addr    (i_load_addr),
        .i_load_data    (i_load_data),
        .o_pc           (pc),
        .o_adder_pc     (adder_pc),
        .o_cycles       (cycles),
        .o_instruction  (instruction),
        .o_halted       (o_halted)
    );

    database database_i (
        .i_clock             (i_clock),
        .i_soft_reset        (i_soft_reset),
        .i_control           (control),
        .i_contador_ciclos   (cycles),
        .i_pc                (pc),
        .i_adder_pc          (adder_pc),
        .i_instruction_fetch (instruction),
        .o_dato              (o_dato)
    );

endmodule

// File: src/database.sv
`timescale 1ns/1ps

`include "mips_debug_defines.svh"

module database (
    input  logic                             i_clock,
    input  logic                             i_soft_reset,
    input  mips_debug_pkg::db_control_e      i_control,
    input  logic [`ADDR_LENGTH-1:0]          i_contador_ciclos,
    input  logic [`ADDR_LENGTH-1:0]          i_pc,
    input  logic [`ADDR_LENGTH-1:0]          i_adder_pc,
    input  logic [`LONGITUD_INSTRUCCION-1:0] i_instruction_fetch,
    output logic [`LONGITUD_INSTRUCCION-1:0] o_dato
);

    import mips_debug_pkg::*;

    localparam int PAD = `LONGITUD_INSTRUCCION - `ADDR_LENGTH;

    logic [`ADDR_LENGTH-1:0]          reg_contador_ciclos;
    logic [`ADDR_LENGTH-1:0]          reg_pc;
    logic [`ADDR_LENGTH-1:0]          reg_adder_pc;
    logic [`LONGITUD_INSTRUCCION-1:0] reg_instruction_fetch;

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            reg_pc                <= '0;
            reg_adder_pc          <= `ADDR_LENGTH'd4;
            reg_instruction_fetch <= '0;
            reg_contador_ciclos   <= '0;
            o_dato                <= '0;
        end else begin
            case (i_control)
                DB_CAPTURE: begin
                    reg_pc                <= i_pc;
                    reg_adder_pc          <= i_adder_pc;
                    reg_instruction_fetch <= i_instruction_fetch;
                    reg_contador_ciclos   <= i_contador_ciclos;
                    o_dato                <= '0; // readout cleared on capture.
                end
                DB_READ_PC: begin
                    o_dato <= {{PAD{1'b0}}, reg_pc};
                end
                DB_READ_CYCLES: begin
                    o_dato <= {{PAD{1'b0}}, reg_contador_ciclos};
                end
                DB_READ_ADDER_PC: begin
                    o_dato <= {{PAD{1'b0}}, reg_adder_pc};
                end
                DB_READ_INSTR: begin
                    o_dato <= reg_instruction_fetch;
                end
                DB_CLEAR: begin
                    // back to the reset snapshot.
                    reg_pc                <= '0;
                    reg_adder_pc          <= `ADDR_LENGTH'd4;
                    reg_instruction_fetch <= '0;
                    reg_contador_ciclos   <= '0;
                    o_dato                <= '0;
                end
                default: begin
                    o_dato <= o_dato; // hold.
                end
            endcase
        end
    end

endmodule

// File: src/instruction_fetch.sv
`timescale 1ns/1ps

`include "mips_debug_defines.svh"

module instruction_fetch (
    input  logic                                i_clock,
    input  logic                                i_soft_reset,
    input  logic                                i_fetch_enable,
    input  logic                                i_load_en,
    input  logic [$clog2(`IMEM_WORDS)-1:0]      i_load_addr,
    input  logic [`LONGITUD_INSTRUCCION-1:0]    i_load_data,
    output logic [`ADDR_LENGTH-1:0]             o_pc,
    output logic [`ADDR_LENGTH-1:0]             o_adder_pc,
    output logic [`ADDR_LENGTH-1:0]             o_cycles,
    output logic [`LONGITUD_INSTRUCCION-1:0]    o_instruction,
    output logic                                o_halted
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    logic [`LONGITUD_INSTRUCCION-1:0] imem [0:`IMEM_WORDS-1];
    logic [IMEM_AW-1:0]               word_index;
    logic                             advance;

    // host load port.
    always_ff @(posedge i_clock) begin
        if (i_load_en) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    // pc is a byte address, drop the two low bits.
    assign word_index    = o_pc[`ADDR_LENGTH-1:2];
    assign o_instruction = imem[word_index];

    // stop on the halt word.
    assign o_halted = (o_instruction == `HALT_WORD);

    // wraps at the address width.
    assign o_adder_pc = o_pc + `ADDR_LENGTH'd4;

    assign advance = i_fetch_enable && !o_halted;

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_pc <= '0;
        end else if (advance) begin
            o_pc <= o_adder_pc;
        end
    end

    // executed fetch cycles.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_cycles <= '0;
        end else if (advance) begin
            o_cycles <= o_cycles + `ADDR_LENGTH'd1;
        end
    end

endmodule

// File: src/debug_command_decode.sv
`timescale 1ns/1ps

module debug_command_decode (
    input  logic                        i_clock,
    input  logic                        i_soft_reset,
    input  logic                        i_cmd_strobe,
    input  mips_debug_pkg::debug_cmd_e  i_cmd,
    output logic                        o_fetch_enable,
    output mips_debug_pkg::db_control_e o_control,
    output logic                        o_running
);

    import mips_debug_pkg::*;

    run_state_e  state;
    run_state_e  state_next;
    db_control_e control_next;
    logic        step_req;

    // run and stop only move the state.
    always_comb begin
        state_next = state;
        if (i_cmd_strobe) begin
            if (i_cmd == CMD_RUN) begin
                state_next = DBG_RUNNING;
            end else if (i_cmd == CMD_STOP) begin
                state_next = DBG_STOPPED;
            end
        end
    end

    // a step while running has no effect.
    assign step_req = i_cmd_strobe && (i_cmd == CMD_STEP) && (state == DBG_STOPPED);

    // command to database code, idle when no strobe.
    always_comb begin
        control_next = DB_HOLD;
        if (i_cmd_strobe) begin
            case (i_cmd)
                CMD_SNAPSHOT:      control_next = DB_CAPTURE;
                CMD_READ_PC:       control_next = DB_READ_PC;
                CMD_READ_CYCLES:   control_next = DB_READ_CYCLES;
                CMD_READ_ADDER_PC: control_next = DB_READ_ADDER_PC;
                CMD_READ_INSTR:    control_next = DB_READ_INSTR;
                CMD_CLEAR:         control_next = DB_CLEAR;
                default:           control_next = DB_HOLD;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            state          <= DBG_STOPPED;
            o_fetch_enable <= 1'b0;
            o_control      <= DB_HOLD;
        end else begin
            state          <= state_next;
            // held while running, one pulse per step.
            o_fetch_enable <= (state_next == DBG_RUNNING) || step_req;
            o_control      <= control_next; // code lasts one cycle.
        end
    end

    assign o_running = (state == DBG_RUNNING);

endmodule

// File: src/mips_debug_pkg.sv
`include "mips_debug_defines.svh"

package mips_debug_pkg;

    // host commands, one-cycle strobes.
    typedef enum logic [3:0] {
        CMD_NOP           = 4'd0,
        CMD_RUN           = 4'd1,
        CMD_STOP          = 4'd2,
        CMD_STEP          = 4'd3,
        CMD_SNAPSHOT      = 4'd4,
        CMD_READ_PC       = 4'd5,
        CMD_READ_CYCLES   = 4'd6,
        CMD_READ_ADDER_PC = 4'd7,
        CMD_READ_INSTR    = 4'd8,
        CMD_CLEAR         = 4'd9
    } debug_cmd_e;

    // database control codes, 0 is idle.
    typedef enum logic [`CANT_BITS_CONTROL-1:0] {
        DB_HOLD          = 3'd0,
        DB_CAPTURE       = 3'd1,
        DB_READ_PC       = 3'd2,
        DB_READ_CYCLES   = 3'd3,
        DB_READ_ADDER_PC = 3'd4,
        DB_READ_INSTR    = 3'd5,
        DB_CLEAR         = 3'd6
    } db_control_e;

    typedef enum logic {
        DBG_STOPPED = 1'b0,
        DBG_RUNNING = 1'b1
    } run_state_e;

endpackage

// File: src/mips_debug_defines.svh
`ifndef MIPS_DEBUG_DEFINES_SVH
`define MIPS_DEBUG_DEFINES_SVH

// byte address width of pc and cycle counter.
`define ADDR_LENGTH 11

// instruction and readout width.
`define LONGITUD_INSTRUCCION 32

// width of the database control code.
`define CANT_BITS_CONTROL 3

// instruction memory depth, whole 11-bit byte space.
`define IMEM_WORDS 512

// stop instruction.
`define HALT_WORD 32'hFFFF_FFFF

`endif
